//--- testbench/mem_trace.txt
# kind vaddr wen wdata bp expected   (I fetch, D load or store, P fetch and load together)
# kind A: vaddr=araddr wen=arlen wdata=arid expected=total AR count, checks first new AR
I 80000104 0 00000000 0 5a5a0104
A 00000100 3 00000000 0 00000001
I 80000100 0 00000000 0 5a5a0100
I 80000108 0 00000000 0 5a5a0108
I 8000010c 0 00000000 0 5a5a010c
A 00000100 3 00000000 0 00000001
I a0000204 0 00000000 0 5a5a0204
A 00000204 0 00000000 0 00000002
I a0000204 0 00000000 0 5a5a0204
A 00000204 0 00000000 0 00000003
D a0000300 3 deadbeef 0 5a5abeef
D a0000300 0 00000000 0 5a5abeef
A 00000300 0 00000001 0 00000004
D 80000310 4 11223344 0 5a220310
D 80000310 0 00000000 0 5a220310
A 00000310 0 00000001 0 00000005
I 80000140 0 00000000 0 5a5a0140
A 00000140 3 00000000 0 00000006
I 80000548 0 00000000 0 5a5a0548
A 00000540 3 00000000 0 00000007
I 80000144 0 00000000 0 5a5a0144
A 00000140 3 00000000 0 00000008
P 80000380 0 00000000 0 5a5a0380
A 00000380 0 00000001 0 0000000a
I 80000604 0 00000000 1 5a5a0604
A 00000600 3 00000000 0 0000000b
I 80000600 0 00000000 1 5a5a0600
I 80000608 0 00000000 1 5a5a0608
I 8000060c 0 00000000 1 5a5a060c
A 00000600 3 00000000 0 0000000b
I a0000204 0 00000000 1 5a5a0204
A 00000204 0 00000000 0 0000000c
I a0000204 0 00000000 1 5a5a0204
A 00000204 0 00000000 0 0000000d
D a0000700 c cafef00d 1 cafe0700
D a0000700 0 00000000 1 cafe0700
A 00000700 0 00000001 0 0000000e

//--- cpu_mem_top.f
common/axi_pkg.sv
common/mem_pkg.sv
common/axi_rd_if.sv
common/axi_wr_if.sv
hw/mmu.sv
icache/icache.sv
hw/data_bridge.sv
hw/axi_arbiter.sv
hw/cpu_mem_top.sv
testbench/tb_cpu_mem_top.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --top-module tb_cpu_mem_top -f cpu_mem_top.f

run: compile
	@out=$$(./obj_dir/Vtb_cpu_mem_top); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- testbench/tb_cpu_mem_top.sv
`timescale 1ns/1ps

module tb_cpu_mem_top import axi_pkg::*; ();
    logic                  aclk;
    logic                  i_rst;
    logic                  i_inst_en;
    logic [31:0]           i_inst_vaddr;
    logic [31:0]           o_inst_rdata;
    logic                  o_i_stall;
    logic                  i_data_en;
    logic [3:0]            i_data_wen;
    logic [31:0]           i_data_vaddr;
    logic [31:0]           i_data_wdata;
    logic [1:0]            i_data_size;
    logic [31:0]           o_data_rdata;
    logic                  o_d_stall;
    logic [AXI_ID_W-1:0]   o_arid;
    logic [AXI_ADDR_W-1:0] o_araddr;
    logic [AXI_LEN_W-1:0]  o_arlen;
    logic [2:0]            o_arsize;
    logic [1:0]            o_arburst;
    logic                  o_arvalid;
    logic                  i_arready = 1'b0;
    logic [AXI_ID_W-1:0]   i_rid = '0;
    logic [AXI_DATA_W-1:0] i_rdata = '0;
    logic                  i_rlast = 1'b0;
    logic                  i_rvalid = 1'b0;
    logic                  o_rready;
    logic [AXI_ID_W-1:0]   o_awid;
    logic [AXI_ADDR_W-1:0] o_awaddr;
    logic [AXI_LEN_W-1:0]  o_awlen;
    logic [2:0]            o_awsize;
    logic [1:0]            o_awburst;
    logic                  o_awvalid;
    logic                  i_awready = 1'b0;
    logic [AXI_ID_W-1:0]   o_wid;
    logic [AXI_DATA_W-1:0] o_wdata;
    logic [AXI_STRB_W-1:0] o_wstrb;
    logic                  o_wlast;
    logic                  o_wvalid;
    logic                  i_wready = 1'b0;
    logic [AXI_ID_W-1:0]   i_bid = ID_DATA;
    logic                  i_bvalid = 1'b0;
    logic                  o_bready;

    // slave memory, 16 KB of words
    logic [31:0]         mem [0:4095];
    logic [31:0]         ar_addr_log [$];
    logic [7:0]          ar_len_log [$];
    logic [AXI_ID_W-1:0] ar_id_log [$];
    int                  ar_seen = 0;
    logic                bp_on = 1'b0;
    int                  seed = 37129;
    int                  errors = 0;
    int                  cycles = 0;
    int                  cycle_limit = 100;

    // read burst and write state of the slave
    logic                rd_busy = 1'b0;
    logic [31:0]         rd_addr = '0;
    int                  rd_left = 0;
    logic [AXI_ID_W-1:0] rd_id = '0;
    logic                r_hold = 1'b0;
    logic                aw_got = 1'b0;
    logic                w_got = 1'b0;
    logic                b_pend = 1'b0;
    logic [31:0]         aw_addr = '0;
    logic [31:0]         w_data = '0;
    logic [3:0]          w_strb = '0;

    // trace columns
    logic [7:0]  t_kind [$];
    logic [31:0] t_addr [$];
    logic [3:0]  t_wen [$];
    logic [31:0] t_wdata [$];
    int          t_bp [$];
    logic [31:0] t_exp [$];

    cpu_mem_top UUT (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = (i * 4) ^ 32'h5A5A0000;
        end
    end

    function automatic logic ready_roll();
        logic ok;
        if (!bp_on) begin
            ok = 1'b1;
        end else begin
            ok = (($random(seed) & 3) != 0);
        end
        return ok;
    endfunction

    function automatic logic [1:0] size_for(input logic [3:0] wen);
        case (wen)
            4'b0000, 4'b1111: size_for = 2'd2;
            4'b0011, 4'b1100: size_for = 2'd1;
            default:          size_for = 2'd0;
        endcase
    endfunction

    // AXI slave model samples at the edge and drives 1 ns later
    always @(posedge aclk) begin
        if (i_rst) begin
            rd_busy = 1'b0;
            r_hold  = 1'b0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            b_pend  = 1'b0;
        end else begin
            r_hold = i_rvalid && !o_rready;
            if (i_arready && o_arvalid) begin
                // 4-byte beats, INCR bursts
                if (o_arsize != 3'b010 || o_arburst != 2'b01) begin
                    $display("Mismatch at %0t: AR size %b burst %b, expected 010 and 01",
                             $time, o_arsize, o_arburst);
                    errors++;
                end
                ar_addr_log.push_back(o_araddr);
                ar_len_log.push_back(o_arlen);
                ar_id_log.push_back(o_arid);
                rd_addr = o_araddr;
                rd_left = int'(o_arlen) + 1;
                rd_id   = o_arid;
                rd_busy = 1'b1;
            end
            if (i_rvalid && o_rready) begin
                rd_addr = rd_addr + 4;
                rd_left = rd_left - 1;
                if (rd_left == 0) begin
                    rd_busy = 1'b0;
                end
            end
            if (i_bvalid && o_bready) begin
                b_pend = 1'b0;
            end
            if (i_awready && o_awvalid) begin
                if (o_awid != ID_DATA || o_awlen != 8'd0 || o_awsize != 3'b010 ||
                    o_awburst != 2'b01) begin
                    $display("Mismatch at %0t: AW id %0d len %0d size %b burst %b",
                             $time, o_awid, o_awlen, o_awsize, o_awburst);
                    $display("  expected id %0d len 0 size 010 burst 01", ID_DATA);
                    errors++;
                end
                aw_got  = 1'b1;
                aw_addr = o_awaddr;
            end
            if (i_wready && o_wvalid) begin
                if (o_wid != ID_DATA || o_wlast != 1'b1) begin
                    $display("Mismatch at %0t: W id %0d last %b, expected id %0d last 1",
                             $time, o_wid, o_wlast, ID_DATA);
                    errors++;
                end
                w_got  = 1'b1;
                w_data = o_wdata;
                w_strb = o_wstrb;
            end
            if (aw_got && w_got && !b_pend) begin
                for (int b = 0; b < 4; b++) begin
                    if (w_strb[b]) begin
                        mem[aw_addr[13:2]][8*b +: 8] = w_data[8*b +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_pend = 1'b1;
            end
        end
        #1;
        i_arready = !rd_busy && ready_roll();
        i_rvalid  = rd_busy && (r_hold || ready_roll());
        i_rdata   = mem[rd_addr[13:2]];
        i_rlast   = (rd_left == 1);
        i_rid     = rd_id;
        i_awready = !aw_got && !b_pend && ready_roll();
        i_wready  = !w_got && !b_pend && ready_roll();
        i_bvalid  = b_pend;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: trace still running after %0d cycles, %0d errors so far",
                     cycles, errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic load_trace();
        int          fd;
        int          c;
        int          n;
        logic [7:0]  k;
        logic [31:0] a;
        logic [3:0]  w;
        logic [31:0] d;
        int          b;
        logic [31:0] e;
        fd = $fopen("testbench/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/mem_trace.txt");
            errors++;
        end else begin
            c = $fgetc(fd);
            while (c >= 0) begin
                k = 8'(c);
                if (k == "#") begin
                    while (c >= 0 && k != "\n") begin
                        c = $fgetc(fd);
                        k = 8'(c);
                    end
                end else if (k == "I" || k == "D" || k == "P" || k == "A") begin
                    n = $fscanf(fd, "%h %h %h %d %h", a, w, d, b, e);
                    if (n != 5) begin
                        $display("trace entry %0d is malformed", t_kind.size());
                        errors++;
                    end else begin
                        t_kind.push_back(k);
                        t_addr.push_back(a);
                        t_wen.push_back(w);
                        t_wdata.push_back(d);
                        t_bp.push_back(b);
                        t_exp.push_back(e);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // starts at 1 ns past an edge, returns at 1 ns past the edge that took the request
    task automatic run_request(input logic use_inst, input logic use_data,
                               input logic [31:0] va, input logic [3:0] wen,
                               input logic [31:0] wdata,
                               output logic [31:0] inst_got, output logic [31:0] data_got);
        logic i_done;
        logic d_done;
        i_done       = !use_inst;
        d_done       = !use_data;
        inst_got     = '0;
        data_got     = '0;
        i_inst_en    = use_inst;
        i_inst_vaddr = va;
        i_data_en    = use_data;
        i_data_vaddr = va;
        i_data_wen   = wen;
        i_data_wdata = wdata;
        i_data_size  = size_for(wen);
        while (!(i_done && d_done)) begin
            @(negedge aclk);
            if (!i_done && !o_i_stall) begin
                inst_got = o_inst_rdata;
                i_done   = 1'b1;
            end
            if (!d_done && !o_d_stall) begin
                data_got = o_data_rdata;
                d_done   = 1'b1;
            end
            @(posedge aclk);
            #1;
            if (i_done) begin
                i_inst_en = 1'b0;
            end
            if (d_done) begin
                i_data_en = 1'b0;
            end
        end
    endtask

    // total AR count, and the first AR since the previous check
    task automatic check_ar(input logic [31:0] addr, input logic [7:0] len,
                            input logic [AXI_ID_W-1:0] id, input int total);
        if (ar_addr_log.size() != total) begin
            $display("Mismatch at %0t: AR count %0d, expected %0d",
                     $time, ar_addr_log.size(), total);
            errors++;
        end
        if (ar_addr_log.size() > ar_seen) begin
            if (ar_addr_log[ar_seen] != addr || ar_len_log[ar_seen] != len ||
                ar_id_log[ar_seen] != id) begin
                $display("Mismatch at %0t: AR addr %h len %0d id %0d, expected %h len %0d id %0d",
                         $time, ar_addr_log[ar_seen], ar_len_log[ar_seen], ar_id_log[ar_seen],
                         addr, len, id);
                errors++;
            end
        end
        ar_seen = ar_addr_log.size();
    endtask

    initial begin
        logic [31:0] inst_got;
        logic [31:0] data_got;
        i_rst        = 1'b1;
        i_inst_en    = 1'b0;
        i_inst_vaddr = '0;
        i_data_en    = 1'b0;
        i_data_wen   = '0;
        i_data_vaddr = '0;
        i_data_wdata = '0;
        i_data_size  = 2'd2;
        load_trace();
        cycle_limit = t_kind.size() * 40 + 100;
        repeat (5) @(posedge aclk);
        #1;
        i_rst = 1'b0;
        for (int i = 0; i < t_kind.size(); i++) begin
            bp_on = (t_bp[i] != 0);
            case (t_kind[i])
                "I": begin
                    run_request(1'b1, 1'b0, t_addr[i], 4'd0, '0, inst_got, data_got);
                    if (inst_got != t_exp[i]) begin
                        $display("Mismatch at %0t: fetch %h returned %h, expected %h",
                                 $time, t_addr[i], inst_got, t_exp[i]);
                        errors++;
                    end
                end
                "D": begin
                    run_request(1'b0, 1'b1, t_addr[i], t_wen[i], t_wdata[i],
                                inst_got, data_got);
                    if (t_wen[i] == 4'd0 && data_got != t_exp[i]) begin
                        $display("Mismatch at %0t: load %h returned %h, expected %h",
                                 $time, t_addr[i], data_got, t_exp[i]);
                        errors++;
                    end
                    if (t_wen[i] != 4'd0 && mem[t_addr[i][13:2]] != t_exp[i]) begin
                        $display("Mismatch at %0t: store %h left %h in memory, expected %h",
                                 $time, t_addr[i], mem[t_addr[i][13:2]], t_exp[i]);
                        errors++;
                    end
                end
                "P": begin
                    run_request(1'b1, 1'b1, t_addr[i], 4'd0, '0, inst_got, data_got);
                    if (inst_got != t_exp[i] || data_got != t_exp[i]) begin
                        $display("Mismatch at %0t: pair %h gave fetch %h load %h, expected %h",
                                 $time, t_addr[i], inst_got, data_got, t_exp[i]);
                        errors++;
                    end
                end
                default: begin
                    check_ar(t_addr[i], 8'(t_wen[i]), t_wdata[i][AXI_ID_W-1:0],
                             int'(t_exp[i]));
                end
            endcase
        end
        $display("trace done: %0d entries, %0d errors", t_kind.size(), errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

//--- hw/cpu_mem_top.sv
`timescale 1ns/1ps

module cpu_mem_top import axi_pkg::*; (
    input  logic                  aclk,
    input  logic                  i_rst,
    input  logic                  i_inst_en,
    input  logic [31:0]           i_inst_vaddr,
    output logic [31:0]           o_inst_rdata,
    output logic                  o_i_stall,
    input  logic                  i_data_en,
    input  logic [3:0]            i_data_wen,
    input  logic [31:0]           i_data_vaddr,
    input  logic [31:0]           i_data_wdata,
    input  logic [1:0]            i_data_size,
    output logic [31:0]           o_data_rdata,
    output logic                  o_d_stall,
    output logic [AXI_ID_W-1:0]   o_arid,
    output logic [AXI_ADDR_W-1:0] o_araddr,
    output logic [AXI_LEN_W-1:0]  o_arlen,
    output logic [2:0]            o_arsize,
    output logic [1:0]            o_arburst,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    input  logic [AXI_ID_W-1:0]   i_rid,
    input  logic [AXI_DATA_W-1:0] i_rdata,
    input  logic                  i_rlast,
    input  logic                  i_rvalid,
    output logic                  o_rready,
    output logic [AXI_ID_W-1:0]   o_awid,
    output logic [AXI_ADDR_W-1:0] o_awaddr,
    output logic [AXI_LEN_W-1:0]  o_awlen,
    output logic [2:0]            o_awsize,
    output logic [1:0]            o_awburst,
    output logic                  o_awvalid,
    input  logic                  i_awready,
    output logic [AXI_ID_W-1:0]   o_wid,
    output logic [AXI_DATA_W-1:0] o_wdata,
    output logic [AXI_STRB_W-1:0] o_wstrb,
    output logic                  o_wlast,
    output logic                  o_wvalid,
    input  logic                  i_wready,
    input  logic [AXI_ID_W-1:0]   i_bid,
    input  logic                  i_bvalid,
    output logic                  o_bready
);
    logic [31:0] inst_paddr;
    logic [31:0] data_paddr;
    logic        inst_uncached;

    axi_rd_if inst_rd ();
    axi_rd_if data_rd ();
    axi_wr_if data_wr ();

    // data side is uncached in every segment, so its flag stays open
    mmu u_mmu (
        .i_inst_vaddr    (i_inst_vaddr),
        .i_data_vaddr    (i_data_vaddr),
        .o_inst_paddr    (inst_paddr),
        .o_data_paddr    (data_paddr),
        .o_inst_uncached (inst_uncached),
        .o_data_uncached ()
    );

    icache u_icache (
        .aclk, .i_rst, .i_inst_en,
        .i_inst_paddr (inst_paddr),
        .i_uncached   (inst_uncached),
        .o_inst_rdata, .o_i_stall,
        .m_rd         (inst_rd)
    );

    data_bridge u_data_bridge (
        .aclk, .i_rst, .i_data_en, .i_data_wen,
        .i_data_paddr (data_paddr),
        .i_data_wdata, .i_data_size, .o_data_rdata, .o_d_stall,
        .m_rd         (data_rd),
        .m_wr         (data_wr)
    );

    axi_arbiter u_axi_arbiter (
        .s_inst (inst_rd),
        .s_data (data_rd),
        .s_wr   (data_wr),
        .*
    );
endmodule

//--- hw/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter import axi_pkg::*; (
    input  logic                  aclk,
    input  logic                  i_rst,
    axi_rd_if.slave               s_inst,
    axi_rd_if.slave               s_data,
    axi_wr_if.slave               s_wr,
    output logic [AXI_ID_W-1:0]   o_arid,
    output logic [AXI_ADDR_W-1:0] o_araddr,
    output logic [AXI_LEN_W-1:0]  o_arlen,
    output logic [2:0]            o_arsize,
    output logic [1:0]            o_arburst,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    input  logic [AXI_ID_W-1:0]   i_rid,
    input  logic [AXI_DATA_W-1:0] i_rdata,
    input  logic                  i_rlast,
    input  logic                  i_rvalid,
    output logic                  o_rready,
    output logic [AXI_ID_W-1:0]   o_awid,
    output logic [AXI_ADDR_W-1:0] o_awaddr,
    output logic [AXI_LEN_W-1:0]  o_awlen,
    output logic [2:0]            o_awsize,
    output logic [1:0]            o_awburst,
    output logic                  o_awvalid,
    input  logic                  i_awready,
    output logic [AXI_ID_W-1:0]   o_wid,
    output logic [AXI_DATA_W-1:0] o_wdata,
    output logic [AXI_STRB_W-1:0] o_wstrb,
    output logic                  o_wlast,
    output logic                  o_wvalid,
    input  logic                  i_wready,
    input  logic [AXI_ID_W-1:0]   i_bid,
    input  logic                  i_bvalid,
    output logic                  o_bready
);
    logic lock;
    logic gnt_data;
    logic sel_data;

    // data master wins an idle channel
    assign sel_data = lock ? gnt_data : s_data.arvalid;

    assign o_arid    = sel_data ? ID_DATA : ID_INST;
    assign o_araddr  = sel_data ? s_data.araddr : s_inst.araddr;
    assign o_arlen   = sel_data ? s_data.arlen : s_inst.arlen;
    assign o_arsize  = SIZE_WORD;
    assign o_arburst = BURST_INCR;
    assign o_arvalid = sel_data ? s_data.arvalid : s_inst.arvalid;

    assign s_data.arready = sel_data && i_arready;
    assign s_inst.arready = !sel_data && i_arready;

    assign s_data.rdata  = i_rdata;
    assign s_data.rlast  = i_rlast;
    assign s_data.rvalid = i_rvalid && sel_data && (i_rid == ID_DATA);
    assign s_inst.rdata  = i_rdata;
    assign s_inst.rlast  = i_rlast;
    assign s_inst.rvalid = i_rvalid && !sel_data && (i_rid == ID_INST);
    assign o_rready      = sel_data ? s_data.rready : s_inst.rready;

    // grant is frozen from the first AR until the last R beat
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            lock     <= 1'b0;
            gnt_data <= 1'b0;
        end else if (!lock) begin
            if (o_arvalid) begin
                lock     <= 1'b1;
                gnt_data <= sel_data;
            end
        end else if (i_rvalid && o_rready && i_rlast) begin
            lock <= 1'b0;
        end
    end

    // only the data side writes
    assign o_awid       = ID_DATA;
    assign o_awaddr     = s_wr.awaddr;
    assign o_awlen      = '0;
    assign o_awsize     = SIZE_WORD;
    assign o_awburst    = BURST_INCR;
    assign o_awvalid    = s_wr.awvalid;
    assign s_wr.awready = i_awready;

    assign o_wid       = ID_DATA;
    assign o_wdata     = s_wr.wdata;
    assign o_wstrb     = s_wr.wstrb;
    assign o_wlast     = 1'b1;
    assign o_wvalid    = s_wr.wvalid;
    assign s_wr.wready = i_wready;

    assign s_wr.bvalid = i_bvalid && (i_bid == ID_DATA);
    assign o_bready    = s_wr.bready;
endmodule

//--- hw/data_bridge.sv
`timescale 1ns/1ps

module data_bridge import mem_pkg::*, axi_pkg::*; (
    input  logic                  aclk,
    input  logic                  i_rst,
    input  logic                  i_data_en,
    input  logic [3:0]            i_data_wen,
    input  logic [31:0]           i_data_paddr,
    input  logic [31:0]           i_data_wdata,
    input  logic [1:0]            i_data_size,
    output logic [31:0]           o_data_rdata,
    output logic                  o_d_stall,
    axi_rd_if.master              m_rd,
    axi_wr_if.master              m_wr
);
    typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_WR, S_B, S_DONE} state_t;

    state_t                state;
    vaddr_u                addr_q;
    vaddr_u                rd_addr;
    vaddr_u                wr_addr;
    logic [1:0]            size_q;
    logic [AXI_DATA_W-1:0] wdata_q;
    logic [AXI_STRB_W-1:0] wstrb_q;
    logic                  aw_done;
    logic                  w_done;
    logic                  aw_ok;
    logic                  w_ok;

    // loads are whole words, stores are aligned to their own size
    always_comb begin
        rd_addr = addr_q;
        rd_addr.line.byte_sel = 2'b00;
        wr_addr = addr_q;
        if (size_q == 2'd2) begin
            wr_addr.line.byte_sel = 2'b00;
        end else if (size_q == 2'd1) begin
            wr_addr.line.byte_sel[0] = 1'b0;
        end
    end

    assign aw_ok = aw_done || m_wr.awready;
    assign w_ok  = w_done || m_wr.wready;

    assign o_d_stall = (state == S_IDLE) ? i_data_en : (state != S_DONE);

    assign m_rd.araddr  = rd_addr;
    assign m_rd.arlen   = '0;
    assign m_rd.arvalid = (state == S_AR);
    assign m_rd.rready  = (state == S_R);

    assign m_wr.awaddr  = wr_addr;
    assign m_wr.awvalid = (state == S_WR) && !aw_done;
    assign m_wr.wdata   = wdata_q;
    assign m_wr.wstrb   = wstrb_q;
    assign m_wr.wvalid  = (state == S_WR) && !w_done;
    assign m_wr.bready  = (state == S_B);

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            state   <= S_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (i_data_en) begin
                        state <= (i_data_wen != 4'b0000) ? S_WR : S_AR;
                    end
                end
                S_AR: begin
                    if (m_rd.arready) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (m_rd.rvalid && m_rd.rlast) begin
                        state <= S_DONE;
                    end
                end
                S_WR: begin
                    aw_done <= aw_ok;
                    w_done  <= w_ok;
                    if (aw_ok && w_ok) begin
                        state <= S_B;
                    end
                end
                S_B: begin
                    if (m_wr.bvalid) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && i_data_en) begin
            addr_q  <= i_data_paddr;
            size_q  <= i_data_size;
            wdata_q <= i_data_wdata;
            wstrb_q <= i_data_wen;
        end
        if (state == S_R && m_rd.rvalid) begin
            o_data_rdata <= m_rd.rdata;
        end
    end
endmodule

//--- icache/icache.sv
`timescale 1ns/1ps

module icache import mem_pkg::*; (
    input  logic        aclk,
    input  logic        i_rst,
    input  logic        i_inst_en,
    input  vaddr_u      i_inst_paddr,
    input  logic        i_uncached,
    output logic [31:0] o_inst_rdata,
    output logic        o_i_stall,
    axi_rd_if.master    m_rd
);
    typedef enum logic [1:0] {S_IDLE, S_REQ, S_REFILL} state_t;

    state_t               state;
    logic [TAG_W-1:0]     tag_arr  [NUM_LINES];
    logic [31:0]          data_arr [NUM_LINES][LINE_WORDS];
    logic [NUM_LINES-1:0] line_valid;
    logic [WORD_W-1:0]    beat_cnt;
    logic                 byp_valid;
    logic [31:0]          byp_data;
    logic [IDX_W-1:0]     idx;
    logic                 hit;
    logic                 miss;

    assign idx  = i_inst_paddr.line.index;
    assign hit  = line_valid[idx] && (tag_arr[idx] == i_inst_paddr.line.tag);
    // an uncached fetch goes to the bus unless its beat is already waiting
    assign miss = i_inst_en && !byp_valid && (i_uncached || !hit);

    assign o_i_stall    = (state != S_IDLE) || miss;
    assign o_inst_rdata = byp_valid ? byp_data : data_arr[idx][i_inst_paddr.line.word];

    // cpu holds the address while stalled, so the request is read straight from it
    assign m_rd.arvalid = (state == S_REQ);
    assign m_rd.arlen   = i_uncached ? '0 : REFILL_LEN;
    assign m_rd.araddr  = i_uncached ? {i_inst_paddr[31:2], 2'b00}
                                     : {i_inst_paddr.line.tag, idx, {(WORD_W + 2){1'b0}}};
    assign m_rd.rready  = (state == S_REFILL);

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            line_valid <= '0;
            byp_valid  <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    byp_valid <= 1'b0;
                    if (miss) begin
                        state <= S_REQ;
                        // line is about to be overwritten
                        if (!i_uncached) begin
                            line_valid[idx] <= 1'b0;
                        end
                    end
                end
                S_REQ: begin
                    beat_cnt <= '0;
                    if (m_rd.arready) begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (m_rd.rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (m_rd.rlast) begin
                            state     <= S_IDLE;
                            byp_valid <= i_uncached;
                            if (!i_uncached) begin
                                line_valid[idx] <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // beats land in order, word 0 first
    always_ff @(posedge aclk) begin
        if (state == S_REFILL && m_rd.rvalid) begin
            if (i_uncached) begin
                byp_data <= m_rd.rdata;
            end else begin
                data_arr[idx][beat_cnt] <= m_rd.rdata;
                if (m_rd.rlast) begin
                    tag_arr[idx] <= i_inst_paddr.line.tag;
                end
            end
        end
    end
endmodule

//--- hw/mmu.sv
`timescale 1ns/1ps

module mmu import mem_pkg::*; (
    input  vaddr_u      i_inst_vaddr,
    input  vaddr_u      i_data_vaddr,
    output logic [31:0] o_inst_paddr,
    output logic [31:0] o_data_paddr,
    output logic        o_inst_uncached,
    output logic        o_data_uncached
);
    // result is {uncached, paddr}
    function automatic logic [32:0] translate(vaddr_u va);
        logic [32:0] res;
        res = {1'b0, va};
        if (va.seg.segment == SEG_KSEG0 || va.seg.segment == SEG_KSEG1) begin
            res[31:0] = {3'b000, va.seg.offset};
        end
        res[32] = (va.seg.segment == SEG_KSEG1);
        return res;
    endfunction

    assign {o_inst_uncached, o_inst_paddr} = translate(i_inst_vaddr);
    assign {o_data_uncached, o_data_paddr} = translate(i_data_vaddr);
endmodule

//--- common/axi_wr_if.sv
`timescale 1ns/1ps

interface axi_wr_if import axi_pkg::*; ();
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bvalid
    );
endinterface

//--- common/axi_rd_if.sv
`timescale 1ns/1ps

interface axi_rd_if import axi_pkg::*; ();
    logic [AXI_ADDR_W-1:0] araddr;
    logic [AXI_LEN_W-1:0]  arlen;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;

    modport master (
        output araddr, arlen, arvalid, rready,
        input  arready, rdata, rlast, rvalid
    );

    modport slave (
        input  araddr, arlen, arvalid, rready,
        output arready, rdata, rlast, rvalid
    );
endinterface

//--- common/mem_pkg.sv
package mem_pkg;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 16;
    localparam int WORD_W     = $clog2(LINE_WORDS);
    localparam int IDX_W      = $clog2(NUM_LINES);
    // whatever is left of the 32-bit address above index, word and byte
    localparam int TAG_W      = 32 - IDX_W - WORD_W - 2;

    // burst length code for one line
    localparam logic [7:0] REFILL_LEN = 8'(LINE_WORDS - 1);

    // unmapped windows, kseg0 cached and kseg1 uncached
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef struct packed {
        logic [2:0]  segment;
        logic [28:0] offset;
    } seg_view_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  index;
        logic [WORD_W-1:0] word;
        logic [1:0]        byte_sel;
    } line_view_t;

    typedef union packed {
        seg_view_t  seg;
        line_view_t line;
    } vaddr_u;
endpackage

//--- common/axi_pkg.sv
package axi_pkg;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_LEN_W  = 8;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // master ids on the shared read channel
    localparam logic [AXI_ID_W-1:0] ID_INST = 4'd0;
    localparam logic [AXI_ID_W-1:0] ID_DATA = 4'd1;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [2:0] SIZE_WORD  = 3'b010;
endpackage
